// ==== compile.f ====
+incdir+hw
hw/l2_cache_pkg.sv
hw/l2_req_arbiter.sv
hw/l2_tag_array.sv
hw/l2_data_array.sv
hw/l2_ctrl_fsm.sv
hw/l2_cache_top.sv
verif/l2_cache_sva.sv
verif/l2_cache_tb.sv

// ==== hw/l2_cache_cfg.svh ====
// L2 cache geometry
// word, line, set and way counts plus address field widths
`ifndef L2_CACHE_CFG_SVH
`define L2_CACHE_CFG_SVH

// data sizes
`define L2_WORD_W      32   // bits per word
`define L2_LINE_WORDS  4    // words per line

// organisation
`define L2_SETS        16
`define L2_WAYS        4    // tree plru assumes four

// word address split, tag | index | offset
`define L2_OFFSET_W    2
`define L2_INDEX_W     4
`define L2_TAG_W       6
`define L2_ADDR_W      (`L2_TAG_W + `L2_INDEX_W + `L2_OFFSET_W)

`endif

// ==== hw/l2_cache_pkg.sv ====
// L2 cache types
// address views, request and response payloads, controller states

`include "l2_cache_cfg.svh"

package l2_cache_pkg;

    typedef logic [`L2_WORD_W-1:0]                     l2_word_t;
    typedef logic [`L2_LINE_WORDS-1:0][`L2_WORD_W-1:0] l2_line_t;
    typedef logic [$clog2(`L2_WAYS)-1:0]               l2_way_t;

    typedef logic [`L2_TAG_W-1:0]                      l2_tag_t;
    typedef logic [`L2_INDEX_W-1:0]                    l2_index_t;
    typedef logic [`L2_OFFSET_W-1:0]                   l2_offset_t;
    typedef logic [`L2_ADDR_W-`L2_OFFSET_W-1:0]        l2_line_addr_t;

    typedef struct packed {
        l2_tag_t    tag;
        l2_index_t  index;
        l2_offset_t offset;
    } l2_cache_view_t;

    typedef struct packed {
        l2_line_addr_t line;    // line number seen by memory
        l2_offset_t    offset;
    } l2_mem_view_t;

    // one word address, read as cache fields or as memory line address
    typedef union packed {
        l2_cache_view_t cache;
        l2_mem_view_t   mem;
    } l2_addr_t;

    typedef struct packed {
        l2_addr_t addr;
        logic     wr;       // 1 = store word
        l2_word_t wdata;
    } l2_req_t;

    typedef struct packed {
        l2_word_t rdata;    // zero for writes
    } l2_rsp_t;

    typedef struct packed {
        l2_line_addr_t addr;
        logic          wr;  // 1 = writeback of a dirty line
        l2_line_t      data;
    } mem_req_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_refill,
        st_respond
    } l2_state_t;

endpackage

// ==== hw/l2_cache_top.sv ====
// L2 cache top
// four way write back cache between two requesters and a line wide memory
`timescale 1ns/1ps

module l2_cache_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ic_req_valid,
    output logic                   ic_req_ready,
    input  l2_cache_pkg::l2_req_t  ic_req,
    input  logic                   dc_req_valid,
    output logic                   dc_req_ready,
    input  l2_cache_pkg::l2_req_t  dc_req,
    output logic                   ic_rsp_valid,
    input  logic                   ic_rsp_ready,
    output l2_cache_pkg::l2_rsp_t  ic_rsp,
    output logic                   dc_rsp_valid,
    input  logic                   dc_rsp_ready,
    output l2_cache_pkg::l2_rsp_t  dc_rsp,
    output logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    output l2_cache_pkg::mem_req_t mem_req,
    input  logic                   mem_rsp_valid,
    input  l2_cache_pkg::l2_line_t mem_rsp_line
);
    import l2_cache_pkg::*;

    l2_req_t  busy_req;
    logic     busy_req_valid;
    logic     done;
    l2_word_t done_word;
    logic     hit;
    logic     victim_valid;
    logic     victim_dirty;
    l2_way_t  hit_way;
    l2_way_t  victim_way;
    l2_way_t  way;              // way used by both arrays
    l2_tag_t  victim_tag;
    l2_line_t rd_line;
    l2_word_t rd_word;
    logic     fill_we;
    logic     set_dirty;
    logic     touch;
    logic     line_we;
    logic     word_we;

    l2_req_arbiter l2_req_arbiter_i (
        .clk, .reset,
        .ic_req_valid, .ic_req_ready, .ic_req,
        .dc_req_valid, .dc_req_ready, .dc_req,
        .ic_rsp_valid, .ic_rsp_ready, .ic_rsp,
        .dc_rsp_valid, .dc_rsp_ready, .dc_rsp,
        .busy_req_valid, .busy_req, .done, .done_word
    );

    l2_tag_array l2_tag_array_i (
        .clk, .reset,
        .index     (busy_req.addr.cache.index),
        .tag       (busy_req.addr.cache.tag),
        .fill_we, .set_dirty, .touch,
        .wr_way    (way),
        .hit, .hit_way, .victim_way, .victim_valid, .victim_dirty, .victim_tag
    );

    l2_data_array l2_data_array_i (
        .clk,
        .index     (busy_req.addr.cache.index),
        .offset    (busy_req.addr.cache.offset),
        .way,
        .line_we, .word_we,
        .line_wd   (mem_rsp_line),
        .word_wd   (busy_req.wdata),
        .rd_line, .rd_word
    );

    l2_ctrl_fsm l2_ctrl_fsm_i (
        .clk, .reset,
        .busy_req_valid, .busy_req,
        .hit, .hit_way, .victim_way, .victim_valid, .victim_dirty, .victim_tag,
        .rd_line, .rd_word,
        .done, .done_word,
        .mem_req_valid, .mem_req_ready, .mem_req,
        .mem_rsp_valid, .mem_rsp_line,
        .way, .fill_we, .set_dirty, .touch, .line_we, .word_we
    );

endmodule

// ==== hw/l2_ctrl_fsm.sv ====
// L2 controller
// lookup, dirty writeback, refill and final access; owns the memory request port
`timescale 1ns/1ps

module l2_ctrl_fsm (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     busy_req_valid,
    input  l2_cache_pkg::l2_req_t    busy_req,
    input  logic                     hit,
    input  l2_cache_pkg::l2_way_t    hit_way,
    input  l2_cache_pkg::l2_way_t    victim_way,
    input  logic                     victim_valid,
    input  logic                     victim_dirty,
    input  l2_cache_pkg::l2_tag_t    victim_tag,
    input  l2_cache_pkg::l2_line_t   rd_line,
    input  l2_cache_pkg::l2_word_t   rd_word,
    output logic                     done,
    output l2_cache_pkg::l2_word_t   done_word,
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output l2_cache_pkg::mem_req_t   mem_req,
    input  logic                     mem_rsp_valid,
    input  l2_cache_pkg::l2_line_t   mem_rsp_line,
    output l2_cache_pkg::l2_way_t    way,
    output logic                     fill_we,
    output logic                     set_dirty,
    output logic                     touch,
    output logic                     line_we,
    output logic                     word_we
);
    import l2_cache_pkg::*;

    l2_state_t state;
    l2_state_t state_next;
    l2_way_t   way_q;           // way chosen in lookup
    l2_word_t  word_q;
    l2_addr_t  wb_addr;
    mem_req_t  wb_req;
    mem_req_t  refill_req;
    logic      wb_needed;
    logic      mem_rsp_in;      // answer to the accepted request
    logic      miss;

    assign miss       = (state == st_lookup) & ~hit;
    assign wb_needed  = victim_valid & victim_dirty;
    assign mem_rsp_in = ~mem_req_valid & mem_rsp_valid;

    // victim line address: its tag with the request index
    always_comb begin
        wb_addr              = busy_req.addr;
        wb_addr.cache.tag    = victim_tag;
        wb_addr.cache.offset = '0;
        wb_req               = '{addr: wb_addr.mem.line, wr: 1'b1, data: rd_line};
        refill_req           = '{addr: busy_req.addr.mem.line, wr: 1'b0, data: '0};
    end

    assign way       = (state == st_lookup) ? (hit ? hit_way : victim_way) : way_q;
    assign done      = (state == st_respond);
    assign done_word = word_q;

    always_comb begin
        fill_we   = 1'b0;
        line_we   = 1'b0;
        touch     = 1'b0;
        set_dirty = 1'b0;
        word_we   = 1'b0;
        if ((state == st_lookup && hit) || (state == st_refill && mem_rsp_in)) begin
            fill_we   = (state == st_refill);
            line_we   = (state == st_refill);
            touch     = 1'b1;
            set_dirty = busy_req.wr;    // write allocate stores after the fill
            word_we   = busy_req.wr;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle:      if (busy_req_valid) state_next = st_lookup;
            st_lookup:    state_next = hit ? st_respond : (wb_needed ? st_writeback : st_refill);
            st_writeback: if (mem_rsp_in) state_next = st_refill;
            st_refill:    if (mem_rsp_in) state_next = st_respond;
            default:      state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= st_idle;
            mem_req_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (mem_req_valid & mem_req_ready)
                mem_req_valid <= 1'b0;
            else if (miss || (state == st_writeback && mem_rsp_in))
                mem_req_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_lookup)
            way_q <= way;
        if (miss)
            mem_req <= wb_needed ? wb_req : refill_req;
        else if (state == st_writeback && mem_rsp_in)
            mem_req <= refill_req;     // refill follows the writeback ack
        if (state == st_lookup && hit)
            word_q <= busy_req.wr ? '0 : rd_word;
        else if (state == st_refill && mem_rsp_in)
            word_q <= busy_req.wr ? '0 : mem_rsp_line[busy_req.addr.cache.offset];
    end

endmodule

// ==== hw/l2_data_array.sv ====
// L2 data array
// one line per set and way; line fill, single word write, word select
`timescale 1ns/1ps

`include "l2_cache_cfg.svh"

module l2_data_array (
    input  logic                     clk,
    input  l2_cache_pkg::l2_index_t  index,
    input  l2_cache_pkg::l2_offset_t offset,
    input  l2_cache_pkg::l2_way_t    way,
    input  logic                     line_we,
    input  logic                     word_we,
    input  l2_cache_pkg::l2_line_t   line_wd,
    input  l2_cache_pkg::l2_word_t   word_wd,
    output l2_cache_pkg::l2_line_t   rd_line,
    output l2_cache_pkg::l2_word_t   rd_word
);
    import l2_cache_pkg::*;

    l2_line_t lines_q [`L2_SETS][`L2_WAYS];

    always_ff @(posedge clk) begin
        if (line_we)
            lines_q[index][way] <= line_wd;           // refill from memory
        if (word_we)
            lines_q[index][way][offset] <= word_wd;   // store wins over fill word
    end

    // combinational read of the addressed way
    assign rd_line = lines_q[index][way];
    assign rd_word = rd_line[offset];

endmodule

// ==== hw/l2_req_arbiter.sv ====
// L2 request arbiter
// fixed priority, instruction side first; one request in flight, response routed to its owner
`timescale 1ns/1ps

module l2_req_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ic_req_valid,
    output logic                  ic_req_ready,
    input  l2_cache_pkg::l2_req_t ic_req,
    input  logic                  dc_req_valid,
    output logic                  dc_req_ready,
    input  l2_cache_pkg::l2_req_t dc_req,
    output logic                  ic_rsp_valid,
    input  logic                  ic_rsp_ready,
    output l2_cache_pkg::l2_rsp_t ic_rsp,
    output logic                  dc_rsp_valid,
    input  logic                  dc_rsp_ready,
    output l2_cache_pkg::l2_rsp_t dc_rsp,
    output logic                  busy_req_valid,
    output l2_cache_pkg::l2_req_t busy_req,
    input  logic                  done,
    input  l2_cache_pkg::l2_word_t done_word
);

    logic slot_free;            // registered ready, low in reset
    logic in_flight;
    logic owner_ic;             // who sent the request in flight
    logic ic_accept;
    logic dc_accept;
    logic in_flight_next;
    logic ic_rsp_valid_next;
    logic dc_rsp_valid_next;

    assign ic_req_ready = slot_free;
    assign dc_req_ready = slot_free & ~ic_req_valid;   // ic wins ties
    assign ic_accept    = ic_req_valid & ic_req_ready;
    assign dc_accept    = dc_req_valid & dc_req_ready;

    // fsm may leave idle on the accepting edge itself
    assign busy_req_valid = ic_accept | dc_accept | in_flight;

    always_comb begin
        in_flight_next    = (ic_accept | dc_accept) | (in_flight & ~done);
        ic_rsp_valid_next = (done & owner_ic) | (ic_rsp_valid & ~ic_rsp_ready);
        dc_rsp_valid_next = (done & ~owner_ic) | (dc_rsp_valid & ~dc_rsp_ready);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_free    <= 1'b0;
            in_flight    <= 1'b0;
            owner_ic     <= 1'b0;
            ic_rsp_valid <= 1'b0;
            dc_rsp_valid <= 1'b0;
        end else begin
            slot_free    <= ~in_flight_next & ~ic_rsp_valid_next & ~dc_rsp_valid_next;
            in_flight    <= in_flight_next;
            ic_rsp_valid <= ic_rsp_valid_next;
            dc_rsp_valid <= dc_rsp_valid_next;
            if (ic_accept | dc_accept)
                owner_ic <= ic_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (ic_accept)
            busy_req <= ic_req;
        else if (dc_accept)
            busy_req <= dc_req;
        if (done & owner_ic)
            ic_rsp.rdata <= done_word;
        if (done & ~owner_ic)
            dc_rsp.rdata <= done_word;
    end

endmodule

// ==== hw/l2_tag_array.sv ====
// L2 tag array
// tag, valid and dirty per way, tree plru per set, parallel compare and victim choice
`timescale 1ns/1ps

`include "l2_cache_cfg.svh"

module l2_tag_array (
    input  logic                    clk,
    input  logic                    reset,
    input  l2_cache_pkg::l2_index_t index,
    input  l2_cache_pkg::l2_tag_t   tag,
    input  logic                    fill_we,
    input  logic                    set_dirty,
    input  logic                    touch,
    input  l2_cache_pkg::l2_way_t   wr_way,
    output logic                    hit,
    output l2_cache_pkg::l2_way_t   hit_way,
    output l2_cache_pkg::l2_way_t   victim_way,
    output logic                    victim_valid,
    output logic                    victim_dirty,
    output l2_cache_pkg::l2_tag_t   victim_tag
);
    import l2_cache_pkg::*;

    l2_tag_t             tag_q   [`L2_SETS][`L2_WAYS];
    logic [`L2_WAYS-1:0] valid_q [`L2_SETS];
    logic [`L2_WAYS-1:0] dirty_q [`L2_SETS];
    logic [2:0]          lru_q   [`L2_SETS];   // tree bits, [0] picks the half
    logic                has_invalid;

    // compare all ways, lowest matching way wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (valid_q[index][w] && tag_q[index][w] == tag) begin
                hit     = 1'b1;
                hit_way = l2_way_t'(w);
            end
        end
    end

    always_comb begin
        has_invalid = 1'b0;
        victim_way  = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[index][w]) begin
                has_invalid = 1'b1;
                victim_way  = l2_way_t'(w);     // lowest free way
            end
        end
        if (!has_invalid) begin
            if (!lru_q[index][0])
                victim_way = lru_q[index][1] ? l2_way_t'(1) : l2_way_t'(0);
            else
                victim_way = lru_q[index][2] ? l2_way_t'(3) : l2_way_t'(2);
        end
    end

    assign victim_valid = valid_q[index][victim_way];
    assign victim_dirty = dirty_q[index][victim_way];
    assign victim_tag   = tag_q[index][victim_way];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= '0;
            end
        end else begin
            if (fill_we) begin
                valid_q[index][wr_way] <= 1'b1;
                dirty_q[index][wr_way] <= 1'b0;
            end
            if (set_dirty)
                dirty_q[index][wr_way] <= 1'b1;   // overrides the fill clear
            if (touch) begin
                // point the tree away from the used way
                case (wr_way)
                    0: begin lru_q[index][0] <= 1'b1; lru_q[index][1] <= 1'b1; end
                    1: begin lru_q[index][0] <= 1'b1; lru_q[index][1] <= 1'b0; end
                    2: begin lru_q[index][0] <= 1'b0; lru_q[index][2] <= 1'b1; end
                    default: begin lru_q[index][0] <= 1'b0; lru_q[index][2] <= 1'b0; end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we)
            tag_q[index][wr_way] <= tag;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the L2 cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module l2_cache_tb -Mdir obj_dir -o l2_cache_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/l2_cache_sim > sim.log 2>&1
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== verif/l2_cache_sva.sv ====
// L2 cache assertions
// handshake stability, response ownership and reset behavior
`timescale 1ns/1ps

module l2_cache_sva (
    input logic                   clk,
    input logic                   reset,
    input logic                   ic_req_ready,
    input logic                   dc_req_ready,
    input logic                   ic_rsp_valid,
    input logic                   ic_rsp_ready,
    input l2_cache_pkg::l2_rsp_t  ic_rsp,
    input logic                   dc_rsp_valid,
    input logic                   dc_rsp_ready,
    input l2_cache_pkg::l2_rsp_t  dc_rsp,
    input logic                   mem_req_valid,
    input logic                   mem_req_ready,
    input l2_cache_pkg::mem_req_t mem_req,
    input logic                   done
);

    ic_hold: assert property (@(posedge clk) disable iff (reset)
        ic_rsp_valid && !ic_rsp_ready |=> ic_rsp_valid && $stable(ic_rsp))
        else $error("ic response dropped or changed");
    dc_hold: assert property (@(posedge clk) disable iff (reset)
        dc_rsp_valid && !dc_rsp_ready |=> dc_rsp_valid && $stable(dc_rsp))
        else $error("dc response dropped or changed");
    mem_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("memory request dropped or changed");
    rsp_cause: assert property (@(posedge clk) disable iff (reset)
        $rose(ic_rsp_valid) || $rose(dc_rsp_valid) |-> $past(done))
        else $error("response without a finished request");
    rsp_one: assert property (@(posedge clk) !(ic_rsp_valid && dc_rsp_valid))
        else $error("responses on both ports");
    in_reset: assert property (@(posedge clk)
        reset |=> !ic_rsp_valid && !dc_rsp_valid && !mem_req_valid && !ic_req_ready && !dc_req_ready)
        else $error("output active after a reset cycle");

endmodule

bind l2_cache_top l2_cache_sva l2_cache_sva_i (
    .clk, .reset, .ic_req_ready, .dc_req_ready,
    .ic_rsp_valid, .ic_rsp_ready, .ic_rsp,
    .dc_rsp_valid, .dc_rsp_ready, .dc_rsp,
    .mem_req_valid, .mem_req_ready, .mem_req, .done
);

// ==== verif/l2_cache_tb.sv ====
// L2 cache testbench
// memory model, stimulus table checked against a reference model of cache and memory
`timescale 1ns/1ps

`include "l2_cache_cfg.svh"

module l2_cache_tb;
    import l2_cache_pkg::*;

    typedef struct {
        int      side;          // 0 ic, 1 dc, 2 ic issued together with the next dc entry
        l2_req_t req;
        int      hold;          // cycles of rsp_ready low
        l2_rsp_t exp_rsp;
        logic    exp_hit;
        logic    exp_wb;
        mem_req_t exp_mem;
    } entry_t;

    logic     clk;
    logic     reset;
    logic     ic_req_valid;
    logic     ic_req_ready;
    l2_req_t  ic_req;
    logic     dc_req_valid;
    logic     dc_req_ready;
    l2_req_t  dc_req;
    logic     ic_rsp_valid;
    logic     ic_rsp_ready;
    l2_rsp_t  ic_rsp;
    logic     dc_rsp_valid;
    logic     dc_rsp_ready;
    l2_rsp_t  dc_rsp;
    logic     mem_req_valid;
    logic     mem_req_ready;
    mem_req_t mem_req;
    logic     mem_rsp_valid;
    l2_line_t mem_rsp_line;

    l2_line_t mem [1024];       // memory model contents
    l2_line_t ref_mem [1024];   // reference model view of memory
    l2_line_t ref_line [`L2_SETS][`L2_WAYS];
    l2_tag_t  ref_tag [`L2_SETS][`L2_WAYS];
    logic     ref_v [`L2_SETS][`L2_WAYS];
    logic     ref_d [`L2_SETS][`L2_WAYS];
    logic [2:0] ref_lru [`L2_SETS];
    entry_t   tab [$];
    mem_req_t last_wr;
    int       wr_count = 0;
    int       cycles = 0;
    int       cycle_limit = 1000;
    integer   seed = 88;

    l2_cache_top l2_cache_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("Error: %s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_rsp(input string name, input l2_rsp_t got, input l2_rsp_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            stop_with_error("response word mismatch");
        end
    endtask

    task automatic check_mem(input string name, input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            stop_with_error("writeback request mismatch");
        end
    endtask

    function automatic l2_word_t pattern(int line, int w);
        return 32'hc0de0000 ^ (line << 4) ^ w;   // unique per line and word
    endfunction

    function automatic l2_addr_t mk(int tg, int ix, int of);
        l2_addr_t a;
        a.cache.tag    = tg;
        a.cache.index  = ix;
        a.cache.offset = of;
        return a;
    endfunction

    function automatic void add(int side, bit wr, l2_addr_t a, l2_word_t d, int hold);
        entry_t e;
        e = '{default: '0};
        e.side  = side;
        e.req   = '{addr: a, wr: wr, wdata: d};
        e.hold  = hold;
        tab.push_back(e);
    endfunction

    // reference model: lowest invalid way, else tree plru; write back then refill
    task automatic predict(inout entry_t e);
        l2_tag_t    tg;
        l2_index_t  ix;
        l2_offset_t of;
        int         hw;
        tg = e.req.addr.cache.tag;
        ix = e.req.addr.cache.index;
        of = e.req.addr.cache.offset;
        hw = -1;
        for (int w = 0; w < `L2_WAYS; w++)
            if (hw < 0 && ref_v[ix][w] && ref_tag[ix][w] == tg)
                hw = w;
        e.exp_hit = (hw >= 0);
        if (hw < 0) begin
            for (int w = `L2_WAYS - 1; w >= 0; w--)
                if (!ref_v[ix][w])
                    hw = w;
            if (hw < 0)
                hw = !ref_lru[ix][0] ? (ref_lru[ix][1] ? 1 : 0) : (ref_lru[ix][2] ? 3 : 2);
            if (ref_v[ix][hw] && ref_d[ix][hw]) begin
                e.exp_wb  = 1'b1;
                e.exp_mem = '{addr: {ref_tag[ix][hw], ix}, wr: 1'b1, data: ref_line[ix][hw]};
                ref_mem[{ref_tag[ix][hw], ix}] = ref_line[ix][hw];
            end
            ref_line[ix][hw] = ref_mem[{tg, ix}];
            ref_v[ix][hw]    = 1'b1;
            ref_d[ix][hw]    = 1'b0;
            ref_tag[ix][hw]  = tg;
        end
        case (hw)
            0: begin ref_lru[ix][0] = 1'b1; ref_lru[ix][1] = 1'b1; end
            1: begin ref_lru[ix][0] = 1'b1; ref_lru[ix][1] = 1'b0; end
            2: begin ref_lru[ix][0] = 1'b0; ref_lru[ix][2] = 1'b1; end
            default: begin ref_lru[ix][0] = 1'b0; ref_lru[ix][2] = 1'b0; end
        endcase
        if (e.req.wr) begin
            ref_line[ix][hw][of] = e.req.wdata;
            ref_d[ix][hw]        = 1'b1;
            e.exp_rsp.rdata      = '0;
        end else begin
            e.exp_rsp.rdata = ref_line[ix][hw][of];
        end
    endtask

    // memory model, answers 1 to 4 cycles after acceptance
    initial begin
        mem_req_t r;
        int       delay;
        forever begin
            mem_req_ready = ($random(seed) & 3) != 0;   // stalls about one cycle in four
            if (mem_req_valid && mem_req_ready) begin
                r = mem_req;
                @(negedge clk);                     // accepted on the edge just passed
                mem_req_ready = 1'b0;               // busy until the answer is out
                if (r.wr) begin
                    mem[r.addr] = r.data;
                    last_wr     = r;
                    wr_count++;
                end
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay - 1) @(negedge clk);
                mem_rsp_valid = 1'b1;
                mem_rsp_line  = r.wr ? '0 : mem[r.addr];
                @(negedge clk);
                mem_rsp_valid = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit)
                stop_with_error("simulation ran past its cycle limit");
        end
    end

    // one request on one side, up to the response handshake
    task automatic run_req(input int side, input l2_req_t req, input int hold,
                           output int lat, output l2_rsp_t got);
        logic acc;
        acc = 1'b0;
        if (side == 0) begin
            ic_req       = req;
            ic_req_valid = 1'b1;
            ic_rsp_ready = (hold == 0);
        end else begin
            dc_req       = req;
            dc_req_valid = 1'b1;
            dc_rsp_ready = (hold == 0);
        end
        while (!acc) begin
            #1;                                     // ready sampled after the drive settles
            acc = (side == 0) ? ic_req_ready : dc_req_ready;
            if (side == 0 && dc_req_valid && dc_req_ready)
                stop_with_error("data side accepted while instruction side was valid");
            @(negedge clk);
        end
        ic_req_valid = 1'b0;
        if (side != 0)
            dc_req_valid = 1'b0;
        lat = 0;
        while (!((side == 0) ? ic_rsp_valid : dc_rsp_valid)) begin
            if ((side == 0) ? dc_rsp_valid : ic_rsp_valid)
                stop_with_error("response appeared on the wrong port");
            @(negedge clk);
            lat++;
        end
        got = (side == 0) ? ic_rsp : dc_rsp;
        repeat (hold) begin
            @(negedge clk);
            if (!((side == 0) ? ic_rsp_valid : dc_rsp_valid) ||
                got !== ((side == 0) ? ic_rsp : dc_rsp))
                stop_with_error("response changed while rsp_ready was low");
            if (ic_req_ready || dc_req_ready)
                stop_with_error("request ready high while a response was pending");
        end
        ic_rsp_ready = 1'b1;
        dc_rsp_ready = 1'b1;
        @(negedge clk);                             // handshake on the edge just passed
        if (ic_rsp_valid || dc_rsp_valid)
            stop_with_error("response still valid after its handshake");
    endtask

    task automatic apply_entry(input entry_t e, input int side);
        int      lat;
        int      wr_before;
        l2_rsp_t got;
        wr_before = wr_count;
        run_req(side, e.req, e.hold, lat, got);
        check_rsp(side == 0 ? "ic_rsp" : "dc_rsp", got, e.exp_rsp);
        if (e.exp_hit && lat != 2)
            stop_with_error("hit response not exactly 2 cycles after acceptance");
        if (!e.exp_hit && lat <= 2)
            stop_with_error("expected miss returned with hit latency");
        if (wr_count != wr_before + e.exp_wb)
            stop_with_error("wrong number of writebacks for this request");
        if (e.exp_wb)
            check_mem("mem_req", last_wr, e.exp_mem);
    endtask

    initial begin
        entry_t e;
        int     i;
        reset = 1'b1;
        ic_req_valid = 1'b0;
        dc_req_valid = 1'b0;
        ic_req = '0;
        dc_req = '0;
        ic_rsp_ready = 1'b1;
        dc_rsp_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp_line = '0;
        for (int l = 0; l < 1024; l++)
            for (int w = 0; w < `L2_LINE_WORDS; w++) begin
                mem[l][w]     = pattern(l, w);
                ref_mem[l][w] = pattern(l, w);
            end
        for (int s = 0; s < `L2_SETS; s++) begin
            ref_lru[s] = '0;
            for (int w = 0; w < `L2_WAYS; w++) begin
                ref_v[s][w] = 1'b0;
                ref_d[s][w] = 1'b0;
            end
        end
        add(0, 0, mk(1, 1, 2), 0, 0);               // read miss then hit
        add(0, 0, mk(1, 1, 3), 0, 0);
        add(1, 1, mk(2, 2, 1), 32'hdead0001, 0);    // write allocate
        add(1, 0, mk(2, 2, 1), 0, 0);
        add(1, 0, mk(2, 2, 0), 0, 0);
        for (int t = 1; t <= 4; t++)
            add(1, 0, mk(t, 3, t - 1), 0, 0);       // fill set 3
        add(1, 1, mk(2, 3, 1), 32'hbeef0002, 0);    // way 1 dirty
        add(0, 0, mk(1, 3, 0), 0, 0);
        add(0, 0, mk(4, 3, 3), 0, 0);               // plru now points at way 1
        add(1, 0, mk(5, 3, 0), 0, 0);               // evicts the dirty line
        add(1, 0, mk(2, 3, 1), 0, 0);               // written word back from memory
        add(2, 0, mk(7, 4, 0), 0, 0);               // both sides at once
        add(1, 0, mk(8, 5, 1), 0, 0);
        add(1, 0, mk(1, 1, 2), 0, 3);               // response back-pressure
        add(0, 0, mk(2, 2, 1), 0, 2);               // same on the ic side
        for (int s = 0; s < `L2_SETS; s++)
            if (s == 0 || s > 5)
                add(0, 0, mk(6'h2a, s, s % 4), 0, 0);
        foreach (tab[k]) begin
            e = tab[k];
            predict(e);
            tab[k] = e;
        end
        cycle_limit = 200 * tab.size();
        repeat (5) begin
            @(negedge clk);
            if (ic_req_ready || dc_req_ready || ic_rsp_valid || dc_rsp_valid || mem_req_valid)
                stop_with_error("valid or ready high during reset");
        end
        reset = 1'b0;
        i = 0;
        while (i < tab.size()) begin
            if (tab[i].side == 2) begin
                dc_req       = tab[i + 1].req;
                dc_req_valid = 1'b1;                // waits behind the ic request
                apply_entry(tab[i], 0);
                apply_entry(tab[i + 1], 1);
                i += 2;
            end else begin
                apply_entry(tab[i], tab[i].side);
                i++;
            end
        end
        repeat (2) @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule
